/* verilog/hps_link_pkg.sv */
/*
 * hps_link shared definitions
 * word and register types of the host command link,
 * the command code set and the key frame skip marker
 */

package hps_link_pkg;

	////////////////////////////////////////
	// widths with a meaning
	////////////////////////////////////////

	// one word on the host bus
	typedef logic [15:0] io_word_t;

	// one joystick button set
	typedef logic [31:0] joy_t;

	// core status register, filled 16 bits at a time
	typedef logic [127:0] status_t;

	// [10] toggle, [9] pressed, [8] extended, [7:0] scan code
	typedef logic [10:0] key_event_t;

	// word index in a frame, saturates at 63
	typedef logic [5:0] word_cnt_t;

	////////////////////////////////////////
	// command codes
	////////////////////////////////////////

	typedef enum logic [15:0] {
		CMD_CFG      = 16'h0001,
		CMD_JOY0     = 16'h0002,
		CMD_JOY1     = 16'h0003,
		CMD_KEY      = 16'h0005,
		CMD_JOY2     = 16'h0010,
		CMD_JOY3     = 16'h0011,
		CMD_JOY4     = 16'h0012,
		CMD_JOY5     = 16'h0013,
		CMD_CONF_STR = 16'h0014,
		CMD_STATUS   = 16'h001E
	} hps_cmd_e;

	localparam int NUM_JOY = 6;

	// upper byte that marks a key word to be dropped
	localparam logic [7:0] SKIP_MARK = 8'hFF;

endpackage

/* verilog/cmd_frame.sv */
/*
 * host command frame tracker
 * latches the command word, counts data words and
 * registers the response word for the host
 */

`timescale 1ns/10ps

module cmd_frame (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  hps_link_pkg::io_word_t io_din,
	input  logic [7:0]             conf_byte,
	output hps_link_pkg::hps_cmd_e cmd,
	output hps_link_pkg::word_cnt_t word_cnt,
	output logic                   wr_stb,
	output logic                   frame_end,
	output hps_link_pkg::io_word_t io_dout
);
	import hps_link_pkg::*;

	logic     enable_q;
	io_word_t dout_q;
	io_word_t rd_word;
	logic     cmd_stb;

	// first strobe of a frame carries the command
	assign cmd_stb = io_enable & io_strobe & (word_cnt == '0);
	assign wr_stb  = io_enable & io_strobe & (word_cnt != '0);

	// only the config string is readable
	assign rd_word = (cmd == CMD_CONF_STR && word_cnt != '0) ? {8'h00, conf_byte} : '0;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd       <= hps_cmd_e'(16'h0000);
			word_cnt  <= '0;
			enable_q  <= 1'b0;
			frame_end <= 1'b0;
			dout_q    <= '0;
		end else begin
			enable_q  <= io_enable;
			frame_end <= enable_q & ~io_enable;
			// keep cmd through frame_end so consumers can close the frame
			if (frame_end)
				cmd <= hps_cmd_e'(16'h0000);
			if (cmd_stb)
				cmd <= hps_cmd_e'(io_din);
			if (!io_enable) begin
				word_cnt <= '0;
				dout_q   <= '0;
			end else if (io_strobe) begin
				if (word_cnt != '1)
					word_cnt <= word_cnt + 1'b1;
				dout_q <= rd_word;
			end
		end
	end

	// bus is released as soon as enable drops
	assign io_dout = io_enable ? dout_q : '0;

endmodule

/* verilog/input_regs.sv */
/*
 * host write registers
 * configuration bits, six joystick button sets and
 * the 128-bit status word
 */

`timescale 1ns/10ps

module input_regs (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  hps_link_pkg::hps_cmd_e  cmd,
	input  hps_link_pkg::word_cnt_t word_cnt,
	input  logic                    wr_stb,
	input  hps_link_pkg::io_word_t  io_din,
	output hps_link_pkg::joy_t      joystick [hps_link_pkg::NUM_JOY],
	output hps_link_pkg::status_t   status,
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video
);
	import hps_link_pkg::*;

	logic       joy_hit;
	logic [2:0] joy_idx;
	logic       status_hit;
	logic [2:0] status_slice;

	////////////////////////////////////////
	// command decode
	////////////////////////////////////////

	// joystick index follows the command table, not the code order
	always_comb begin
		joy_hit = 1'b1;
		joy_idx = 3'd0;
		case (cmd)
			CMD_JOY0: joy_idx = 3'd0;
			CMD_JOY1: joy_idx = 3'd1;
			CMD_JOY2: joy_idx = 3'd2;
			CMD_JOY3: joy_idx = 3'd3;
			CMD_JOY4: joy_idx = 3'd4;
			CMD_JOY5: joy_idx = 3'd5;
			default:  joy_hit = 1'b0;
		endcase
	end

	// words 1 to 8 map onto slices 0 to 7
	assign status_hit   = (cmd == CMD_STATUS) && (word_cnt >= 6'd1) && (word_cnt <= 6'd8);
	assign status_slice = word_cnt[2:0] - 3'd1;

	////////////////////////////////////////
	// register writes
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_JOY; i++)
				joystick[i] <= '0;
			status             <= '0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			direct_video       <= 1'b0;
		end else if (wr_stb) begin
			// config word, only the first data word counts
			if (cmd == CMD_CFG && word_cnt == 6'd1) begin
				buttons            <= io_din[1:0];
				forced_scandoubler <= io_din[4];
				direct_video       <= io_din[10];
			end

			// low half first, any later word lands in the high half
			if (joy_hit) begin
				if (word_cnt == 6'd1)
					joystick[joy_idx][15:0] <= io_din;
				else
					joystick[joy_idx][31:16] <= io_din;
			end

			if (status_hit)
				status[{status_slice, 4'b0000} +: 16] <= io_din;
		end
	end

endmodule

/* verilog/key_decode.sv */
/*
 * PS/2 key event assembly
 * gathers raw scan-code bytes of a key frame and turns
 * them into one key event when the frame closes
 */

`timescale 1ns/10ps

module key_decode (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  hps_link_pkg::hps_cmd_e   cmd,
	input  logic                     wr_stb,
	input  logic                     frame_end,
	input  hps_link_pkg::io_word_t   io_din,
	output hps_link_pkg::key_event_t ps2_key
);
	import hps_link_pkg::*;

	logic [31:0] key_raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	key_event_t  key_next;

	// F0 before the code means release
	assign pressed  = (key_raw[15:8] != 8'hF0);
	assign extended = pressed ? (key_raw[15:8] == 8'hE0) : (key_raw[23:16] == 8'hE0);

	always_comb begin
		key_next = {~ps2_key[10], pressed, extended, key_raw[7:0]};
		// print screen and pause come as multi-byte sequences
		case (key_raw)
			32'hE012E07C: key_next[9:0] = 10'h37C;
			32'h7CE0F012: key_next[9:0] = 10'h17C;
			32'hF014F077: key_next[9:0] = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			key_raw <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else if (frame_end) begin
			if (cmd == CMD_KEY && !skip)
				ps2_key <= key_next;
			// history starts empty for the next frame
			key_raw <= '0;
			skip    <= 1'b0;
		end else if (wr_stb && cmd == CMD_KEY) begin
			if (io_din[15:8] == SKIP_MARK)
				skip <= 1'b1;
			else if (!skip)
				key_raw <= {key_raw[23:0], io_din[7:0]};
		end
	end

endmodule

/* verilog/conf_rom.sv */
/*
 * configuration string ROM
 * one character per address, first character first,
 * zero past the end of the string
 */

`timescale 1ns/10ps

module conf_rom #(
	parameter CONF_STR = "hps_link"
) (
	input  logic                    clk_sys,
	input  hps_link_pkg::word_cnt_t word_cnt,
	output logic [7:0]              conf_byte
);
	import hps_link_pkg::*;

	localparam int STRLEN = $bits(CONF_STR) / 8;
	localparam int DEPTH  = 2 ** $bits(word_cnt_t);

	logic [7:0] rom [DEPTH];
	word_cnt_t  rom_addr;

	// leftmost character of the literal sits in the top byte
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			if (i < STRLEN)
				rom[i] = CONF_STR[(STRLEN - i) * 8 - 1 -: 8];
			else
				rom[i] = 8'h00;
		end
	end

	// data word k reads character k-1
	assign rom_addr = word_cnt - 6'd1;

	always_ff @(posedge clk_sys) begin
		conf_byte <= rom[rom_addr];
	end

endmodule

/* verilog/hps_link.sv */
/*
 * hps_link top level
 * host command link core: frame tracker feeding the
 * input registers, the key decoder and the config ROM
 */

`timescale 1ns/10ps

module hps_link #(
	parameter CONF_STR = "hps_link"
) (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     io_enable,
	input  logic                     io_strobe,
	input  hps_link_pkg::io_word_t   io_din,
	output hps_link_pkg::io_word_t   io_dout,
	output hps_link_pkg::joy_t       joystick_0,
	output hps_link_pkg::joy_t       joystick_1,
	output hps_link_pkg::joy_t       joystick_2,
	output hps_link_pkg::joy_t       joystick_3,
	output hps_link_pkg::joy_t       joystick_4,
	output hps_link_pkg::joy_t       joystick_5,
	output hps_link_pkg::status_t    status,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic                     direct_video,
	output hps_link_pkg::key_event_t ps2_key
);
	import hps_link_pkg::*;

	hps_cmd_e   cmd;
	word_cnt_t  word_cnt;
	logic       wr_stb;
	logic       frame_end;
	logic [7:0] conf_byte;
	joy_t       joystick [NUM_JOY];

	cmd_frame cmd_frame_inst (
		.clk_sys, .rst_n, .io_enable, .io_strobe, .io_din,
		.conf_byte, .cmd, .word_cnt, .wr_stb, .frame_end, .io_dout
	);

	input_regs input_regs_inst (
		.clk_sys, .rst_n, .cmd, .word_cnt, .wr_stb, .io_din,
		.joystick, .status, .buttons, .forced_scandoubler, .direct_video
	);

	key_decode key_decode_inst (
		.clk_sys, .rst_n, .cmd, .wr_stb, .frame_end, .io_din, .ps2_key
	);

	conf_rom #(
		.CONF_STR(CONF_STR)
	) conf_rom_inst (
		.clk_sys, .word_cnt, .conf_byte
	);

	// one port per joystick
	assign joystick_0 = joystick[0];
	assign joystick_1 = joystick[1];
	assign joystick_2 = joystick[2];
	assign joystick_3 = joystick[3];
	assign joystick_4 = joystick[4];
	assign joystick_5 = joystick[5];

endmodule

/* sim/hps_link_checker.sv */
/*
 * hps_link bus checker
 * assertions on the bus rules seen by the frame tracker
 */

`timescale 1ns/10ps

module hps_link_checker (
	input logic                   clk_sys,
	input logic                   rst_n,
	input logic                   io_enable,
	input logic                   wr_stb,
	input hps_link_pkg::hps_cmd_e cmd,
	input hps_link_pkg::io_word_t io_dout
);
	import hps_link_pkg::*;

	// no response outside a frame
	assert property (@(posedge clk_sys) disable iff (!rst_n) !io_enable |-> io_dout == '0)
		else $error("io_dout is not zero while io_enable is low");

	// data strobes belong to an open frame
	assert property (@(posedge clk_sys) disable iff (!rst_n) wr_stb |-> io_enable)
		else $error("wr_stb pulsed while io_enable is low");

	// only a config string read puts data on the bus
	assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd != CMD_CONF_STR |-> io_dout == '0)
		else $error("io_dout is not zero outside a config string read");

endmodule

/* sim/hps_link_tb.sv */
/*
 * hps_link testbench
 * directed tests of the host command link over the word bus
 */

`timescale 1ns/10ps

module hps_link_tb;
	import hps_link_pkg::*;

	localparam CONF_STR = "V1;O1,Scan";
	localparam int CONF_LEN = $bits(CONF_STR) / 8;
	// the tests need about 300 cycles
	localparam int MAX_CYCLES = 4000;
	localparam hps_cmd_e JOY_CMDS [NUM_JOY] = '{CMD_JOY0, CMD_JOY1, CMD_JOY2,
		CMD_JOY3, CMD_JOY4, CMD_JOY5};

	logic clk_sys;
	logic rst_n = 1'b0;
	logic io_enable = 1'b0;
	logic io_strobe = 1'b0;
	io_word_t io_din = '0;
	io_word_t io_dout;
	joy_t joy_out [NUM_JOY];
	status_t status;
	logic [1:0] buttons;
	logic forced_scandoubler;
	logic direct_video;
	key_event_t ps2_key;
	// expected DUT outputs
	joy_t joy_exp [NUM_JOY] = '{default: '0};
	status_t status_exp = '0;
	logic [3:0] cfg_exp = '0;
	key_event_t key_exp = '0;
	logic [31:0] lfsr = 32'he804;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	hps_link #(.CONF_STR(CONF_STR)) hps_link_inst (.*, .joystick_0(joy_out[0]),
		.joystick_1(joy_out[1]), .joystick_2(joy_out[2]), .joystick_3(joy_out[3]),
		.joystick_4(joy_out[4]), .joystick_5(joy_out[5]));

	bind cmd_frame hps_link_checker hps_link_checker_inst (.clk_sys, .rst_n,
		.io_enable, .wr_stb, .cmd, .io_dout);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// galois lfsr, one step per bit
	function automatic io_word_t random_word();
		io_word_t w;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
			w[i] = lfsr[0];
		end
		return w;
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic check_outputs(input string name);
		for (int i = 0; i < NUM_JOY; i++)
			check_value($sformatf("%s joystick_%0d", name, i), joy_exp[i], joy_out[i]);
		check_value({name, " status"}, status_exp, status);
		check_value({name, " cfg"}, cfg_exp, {buttons, forced_scandoubler, direct_video});
		check_value({name, " ps2_key"}, key_exp, ps2_key);
		check_value({name, " io_dout"}, 0, io_dout);
	endtask

	////////////////////////////////////////
	// host bus
	////////////////////////////////////////

	task automatic send_word(input io_word_t w);
		@(posedge clk_sys);
		#1 io_din = w;
		io_strobe = 1'b1;
		@(posedge clk_sys);
		#1 io_strobe = 1'b0;
	endtask

	task automatic send_cmd(input hps_cmd_e c);
		@(posedge clk_sys);
		#1 io_enable = 1'b1;
		send_word(c);
	endtask

	// enable drops late enough for the key update to land before return
	task automatic end_frame();
		repeat (2) @(posedge clk_sys);
		#1 io_enable = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
	endtask

	// response must still be there right before the next strobe
	task automatic read_word(output io_word_t data);
		send_word('0);
		@(posedge clk_sys);
		@(negedge clk_sys) data = io_dout;
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic test_idle();
		check_outputs("reset");
		// strobes outside a frame
		send_word(CMD_CFG);
		send_word(16'hFFFF);
		send_word(CMD_STATUS);
		send_word(16'hFFFF);
		check_outputs("idle strobes");
	endtask

	task automatic test_cfg();
		io_word_t w;
		w = random_word();
		send_cmd(CMD_CFG);
		send_word(w);
		cfg_exp = {w[1:0], w[4], w[10]};
		check_outputs("cfg");
		end_frame();
	endtask

	task automatic test_joystick();
		io_word_t lo;
		io_word_t hi;
		for (int i = 0; i < NUM_JOY; i++) begin
			lo = random_word();
			hi = random_word();
			send_cmd(JOY_CMDS[i]);
			send_word(lo);
			joy_exp[i][15:0] = lo;
			check_outputs($sformatf("joystick %0d low", i));
			send_word(hi);
			joy_exp[i][31:16] = hi;
			check_outputs($sformatf("joystick %0d high", i));
			end_frame();
		end
	endtask

	task automatic test_status();
		io_word_t w;
		send_cmd(CMD_STATUS);
		for (int s = 0; s < 8; s++) begin
			w = random_word();
			send_word(w);
			status_exp[s * 16 +: 16] = w;
		end
		check_outputs("status");
		// ninth word is past the register
		send_word(random_word());
		check_outputs("status ninth word");
		end_frame();
	endtask

	task automatic test_conf_str();
		io_word_t data;
		logic [7:0] ch;
		send_cmd(CMD_CONF_STR);
		for (int k = 1; k <= CONF_LEN + 2; k++) begin
			read_word(data);
			ch = 8'h00;
			// first character sits in the top byte of the literal
			if (k <= CONF_LEN)
				ch = CONF_STR[(CONF_LEN - k) * 8 +: 8];
			check_value($sformatf("conf_str word %0d", k), {8'h00, ch}, data);
		end
		end_frame();
	endtask

	task automatic key_frame(input string name, input logic [31:0] seq, input int n,
			input logic [9:0] expected);
		send_cmd(CMD_KEY);
		for (int i = n - 1; i >= 0; i--)
			send_word({8'h00, seq[i * 8 +: 8]});
		end_frame();
		// toggle flips once per accepted frame
		key_exp = {~key_exp[10], expected};
		check_outputs(name);
	endtask

	task automatic test_keys();
		key_frame("key plain", 32'h1C, 1, 10'h21C);
		key_frame("key release", 32'hF01C, 2, 10'h01C);
		key_frame("key extended", 32'hE075, 2, 10'h375);
		key_frame("key extended release", 32'hE0F075, 3, 10'h175);
		key_frame("key print screen", 32'hE012E07C, 4, 10'h37C);
		key_frame("key print screen release", 32'h7CE0F012, 4, 10'h17C);
		key_frame("key pause", 32'hF014F077, 4, 10'h377);
		// marker word drops the whole frame
		send_cmd(CMD_KEY);
		send_word(16'h00E0);
		send_word({SKIP_MARK, 8'h00});
		send_word(16'h001C);
		end_frame();
		check_outputs("key skipped");
	endtask

	initial begin
		repeat (16) @(posedge clk_sys);
		#1 rst_n = 1'b1;
		test_idle();
		test_cfg();
		test_joystick();
		test_status();
		test_conf_str();
		test_keys();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* hps_link.f */
verilog/hps_link_pkg.sv
verilog/cmd_frame.sv
verilog/input_regs.sv
verilog/key_decode.sv
verilog/conf_rom.sv
verilog/hps_link.sv
sim/hps_link_checker.sv
sim/hps_link_tb.sv

/* Makefile */
# Verilator simulation of the hps_link core
TOP := hps_link_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f hps_link.f
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
		test $$status -eq 0 && ! grep -q "TESTBENCH FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
